// ==== all.f ====
sys_pkg.sv
download_decoder.sv
half_word_packer.sv
ram_write_port.sv
psx_download_top.sv
tb_ram_model.sv
tb_psx_download.sv

// ==== Makefile ====
# Verilator build and run of the download testbench

BIN := obj_dir/Vtb_psx_download

# Rebuilt only when a source or the file list changes
$(BIN): all.f $(shell cat all.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_psx_download -f all.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tb_psx_download.sv ====
// Testbench for the host download block. Applies a table of downloads
// (BIOS, EXE, track info, cheat code, unknown index) and checks the RAM
// writes, track port, cheat code and pulses against the expected values.

`timescale 1ns/1ps

module tb_psx_download import sys_pkg::*; ();

	localparam int BIOS_START = 2097152;
	localparam int EXE_START  = 4194304;
	localparam int NUM_STEPS  = 5;
	localparam int MAX_WAIT   = 50;

	typedef struct packed {
		logic [7:0]       index;
		ram_addr_t        offset;
		logic [3:0]       count;
		logic [7:0][15:0] halves;
		logic [3:0]       exp_ram;
		logic             exp_track;
		logic             exp_code;
		logic             exp_load;
		logic             exp_reset;
		cheat_code_t      exp_code_value;
	} step_t;

	logic        clk_1x;
	logic        rst_n;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_wr;
	ram_addr_t   dl_addr;
	half_t       dl_data;
	logic        dl_wait;
	logic        ram_req;
	ram_addr_t   ram_addr;
	ram_word_t   ram_data;
	logic        ram_done;
	logic        track_wr;
	track_addr_t track_addr;
	ram_word_t   track_data;
	cheat_code_t code;
	logic        code_valid;
	logic        code_reset;
	logic        load_exe;

	step_t       steps [NUM_STEPS];
	int          checks = 0;
	int          errors = 0;
	int          track_count = 0;
	int          code_count = 0;
	int          load_count = 0;
	int          reset_count = 0;
	int          wait_cycles = 0;
	track_addr_t last_track_addr;
	ram_word_t   last_track_data;
	cheat_code_t last_code;
	logic        wait_q = 1'b0;
	logic        done_seen = 1'b0;

	psx_download_top #(.BIOS_START(BIOS_START), .EXE_START(EXE_START)) dut (
		.clk_1x (clk_1x), .rst_n (rst_n), .dl_active (dl_active), .dl_index (dl_index),
		.dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data), .dl_wait (dl_wait),
		.ram_req (ram_req), .ram_addr (ram_addr), .ram_data (ram_data),
		.ram_done (ram_done), .track_wr (track_wr), .track_addr (track_addr),
		.track_data (track_data), .code (code), .code_valid (code_valid),
		.code_reset (code_reset), .load_exe (load_exe)
	);

	tb_ram_model ram (
		.clk_1x (clk_1x), .rst_n (rst_n), .ram_req (ram_req),
		.ram_addr (ram_addr), .ram_data (ram_data), .ram_done (ram_done)
	);

	initial begin
		clk_1x = 1'b0;
		forever #10 clk_1x = ~clk_1x;
	end

	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, expected);
		end
	endtask

	function automatic step_t make_step(input logic [7:0] index, input ram_addr_t offset,
		input int count, input logic [127:0] halves, input int exp_ram, input logic exp_track,
		input logic exp_code, input logic exp_load, input logic exp_reset,
		input cheat_code_t exp_code_value);
		step_t st;
		st.index = index;
		st.offset = offset;
		st.count = 4'(count);
		st.halves = halves;
		st.exp_ram = 4'(exp_ram);
		st.exp_track = exp_track;
		st.exp_code = exp_code;
		st.exp_load = exp_load;
		st.exp_reset = exp_reset;
		st.exp_code_value = exp_code_value;
		return st;
	endfunction

	// ==================================================
	// Stimulus table with half 0 in the lowest 16 bits
	// ==================================================
	task automatic load_steps();
		steps[0] = make_step(INDEX_BIOS, 27'h100, 4, 128'hFEDC_BA98_7654_3210,
			2, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		steps[1] = make_step(INDEX_EXE, 27'h20, 4, 128'hF0F0_0F0F_5A5A_A5A5,
			2, 1'b0, 1'b0, 1'b1, 1'b0, '0);
		steps[2] = make_step(INDEX_CDINFO, 27'h48, 2, 128'h00AB_00CD,
			0, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		steps[3] = make_step(INDEX_CODE, 27'h0, 8, 128'h8888_7777_6666_5555_4444_3333_2222_1111,
			0, 1'b0, 1'b1, 1'b0, 1'b1, 128'h2222_1111_4444_3333_6666_5555_8888_7777);
		steps[4] = make_step(8'd7, 27'h0, 2, 128'h9999_AAAA,
			0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
	endtask

	// Output monitor sampling the values settled during the last cycle
	always @(posedge clk_1x) begin
		if (rst_n) begin
			if (track_wr) begin
				track_count++;
				last_track_addr = track_addr;
				last_track_data = track_data;
			end
			if (code_valid) begin
				code_count++;
				last_code = code;
			end
			load_count  += int'(load_exe);
			reset_count += int'(code_reset);
			wait_cycles += int'(dl_wait);
			if (ram_done) begin
				done_seen = 1'b1;
			end
			checks++;
			assert (!ram_req || dl_wait) else begin
				errors++;
				$display("ram_req issued while dl_wait was low at %0t", $time);
			end
			if (wait_q && !dl_wait) begin
				checks++;
				assert (done_seen) else begin
					errors++;
					$display("dl_wait fell before the RAM answered at %0t", $time);
				end
			end
			if (!wait_q && dl_wait) begin
				done_seen = 1'b0;
			end
			wait_q = dl_wait;
		end
	end

	task automatic wait_for_release();
		int cycles;
		cycles = 0;
		while (dl_wait && cycles < MAX_WAIT) begin
			@(negedge clk_1x);
			cycles++;
		end
		if (dl_wait) begin
			$display("Timeout: dl_wait stayed high for %0d cycles", MAX_WAIT);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Test failures found");
			$finish;
		end
	endtask

	task automatic write_half(input ram_addr_t addr, input half_t data);
		wait_for_release();
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_1x);
		dl_wr = 1'b0;
	endtask

	task automatic run_step(input int s);
		step_t     st;
		int        h;
		int        ram_before;
		int        track_before;
		int        code_before;
		int        load_before;
		int        reset_before;
		int        wait_before;
		int        base;
		st = steps[s];
		ram_before = ram.wr_count;
		track_before = track_count;
		code_before = code_count;
		load_before = load_count;
		reset_before = reset_count;
		wait_before = wait_cycles;
		dl_index  = st.index;
		dl_active = 1'b1;
		repeat (2) @(negedge clk_1x);
		for (h = 0; h < int'(st.count); h++) begin
			write_half(ram_addr_t'(st.offset + 2 * h), st.halves[h]);
		end
		// Last half reaches ram_req two cycles later
		repeat (2) @(negedge clk_1x);
		wait_for_release();
		dl_active = 1'b0;
		repeat (6) @(negedge clk_1x);

		base = (st.index == INDEX_EXE) ? EXE_START : BIOS_START;
		check_value("ram_req count", ram.wr_count - ram_before, st.exp_ram);
		for (h = 0; h < int'(st.exp_ram); h++) begin
			check_value("ram_addr", ram.wr_addr[ram_before + h],
				ram_addr_t'(st.offset + 4 * h + base));
			check_value("ram_data", ram.wr_data[ram_before + h],
				{st.halves[2 * h + 1], st.halves[2 * h]});
		end
		check_value("track_wr count", track_count - track_before, st.exp_track);
		if (st.exp_track) begin
			check_value("track_addr", last_track_addr, st.offset[10:2]);
			check_value("track_data", last_track_data, {st.halves[1], st.halves[0]});
		end
		if (st.index == INDEX_CDINFO) begin
			check_value("dl_wait cycles", wait_cycles - wait_before, 0);
		end
		check_value("code_valid count", code_count - code_before, st.exp_code);
		if (st.exp_code) begin
			check_value("code", last_code, st.exp_code_value);
		end
		check_value("load_exe count", load_count - load_before, st.exp_load);
		check_value("code_reset count", reset_count - reset_before, st.exp_reset);
	endtask

	initial begin
		int s;
		rst_n     = 1'b0;
		dl_active = 1'b0;
		dl_index  = 8'd0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		load_steps();
		repeat (10) @(negedge clk_1x);
		rst_n = 1'b1;

		// Nothing may move while idle after reset
		repeat (4) @(negedge clk_1x);
		check_value("dl_kind after reset", dut.dl_kind, DL_NONE);
		check_value("control outputs after reset",
			{dl_wait, ram_req, track_wr, code_valid, code_reset, load_exe}, 0);
		check_value("idle RAM requests", ram.wr_count, 0);
		check_value("idle pulses", track_count + code_count + load_count + reset_count, 0);

		for (s = 0; s < NUM_STEPS; s++) begin
			run_step(s);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== tb_ram_model.sv ====
// RAM responder for the download testbench. Answers each write request
// with a one-cycle done after 1 to 8 cycles and keeps a record of the writes.

`timescale 1ns/1ps

module tb_ram_model import sys_pkg::*; (
	input  logic      clk_1x,
	input  logic      rst_n,
	input  logic      ram_req,
	input  ram_addr_t ram_addr,
	input  ram_word_t ram_data,
	output logic      ram_done
);

	// Write record read by the testbench top
	ram_addr_t wr_addr [64];
	ram_word_t wr_data [64];
	int        wr_count;
	int        delay_left;
	integer    seed;

	initial begin
		seed     = 36;
		ram_done = 1'b0;
	end

	// Done leaves on the falling edge like the other DUT inputs
	always @(negedge clk_1x) begin
		if (!rst_n) begin
			ram_done   <= 1'b0;
			wr_count   <= 0;
			delay_left <= 0;
		end else begin
			ram_done <= 1'b0;
			if (ram_req) begin
				wr_addr[wr_count] <= ram_addr;
				wr_data[wr_count] <= ram_data;
				wr_count          <= wr_count + 1;
				delay_left        <= 1 + int'($unsigned($random(seed)) % 8);
			end else if (delay_left != 0) begin
				delay_left <= delay_left - 1;
				if (delay_left == 1) begin
					ram_done <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== psx_download_top.sv ====
// Host download block of the console core: index decoder, two half-word
// packers and the RAM write port. BIOS, EXE and track-info words go through
// the RAM packer, cheat codes through the 128-bit code packer.

`timescale 1ns/1ps

module psx_download_top import sys_pkg::*; #(
	parameter int BIOS_START = 2097152,
	parameter int EXE_START  = 4194304
) (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        dl_active,
	input  logic [7:0]  dl_index,
	input  logic        dl_wr,
	input  ram_addr_t   dl_addr,
	input  half_t       dl_data,
	output logic        dl_wait,
	output logic        ram_req,
	output ram_addr_t   ram_addr,
	output ram_word_t   ram_data,
	input  logic        ram_done,
	output logic        track_wr,
	output track_addr_t track_addr,
	output ram_word_t   track_data,
	output cheat_code_t code,
	output logic        code_valid,
	output logic        code_reset,
	output logic        load_exe
);

	dl_kind_t  dl_kind;
	logic      ram_half_wr;
	logic      code_half_wr;
	logic      word_valid;
	ram_word_t word;
	ram_addr_t word_offset;

	// Half-word strobes split by download kind
	assign ram_half_wr  = dl_wr && ((dl_kind == DL_BIOS) || (dl_kind == DL_EXE) ||
		(dl_kind == DL_CDINFO));
	assign code_half_wr = dl_wr && (dl_kind == DL_CODE);

	download_decoder decoder (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.dl_kind    (dl_kind),
		.load_exe   (load_exe),
		.code_reset (code_reset)
	);

	half_word_packer #(.payload_t(ram_word_t)) ram_packer (
		.clk_1x (clk_1x), .rst_n (rst_n),
		.half_wr (ram_half_wr), .half_offset (dl_addr), .half_data (dl_data),
		.payload (word), .payload_offset (word_offset), .payload_valid (word_valid)
	);

	// Cheat codes carry no address of their own
	half_word_packer #(.payload_t(cheat_code_t)) code_packer (
		.clk_1x (clk_1x), .rst_n (rst_n),
		.half_wr (code_half_wr), .half_offset (dl_addr), .half_data (dl_data),
		.payload (code), .payload_offset (), .payload_valid (code_valid)
	);

	ram_write_port #(.BIOS_START(BIOS_START), .EXE_START(EXE_START)) write_port (
		.clk_1x (clk_1x), .rst_n (rst_n), .dl_kind (dl_kind),
		.word_valid (word_valid), .word (word), .word_offset (word_offset),
		.ram_req (ram_req), .ram_addr (ram_addr), .ram_data (ram_data),
		.ram_done (ram_done),
		.track_wr (track_wr), .track_addr (track_addr), .track_data (track_data),
		.dl_wait (dl_wait)
	);

endmodule

// ==== ram_write_port.sv ====
// Takes packed RAM words and sends them either to the RAM write channel,
// relocated for BIOS or EXE images, or to the CD track table port.
// Holds the host wait from each RAM request until the RAM confirms it.

`timescale 1ns/1ps

module ram_write_port import sys_pkg::*; #(
	parameter int BIOS_START = 2097152,
	parameter int EXE_START  = 4194304
) (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  dl_kind_t    dl_kind,
	input  logic        word_valid,
	input  ram_word_t   word,
	input  ram_addr_t   word_offset,
	output logic        ram_req,
	output ram_addr_t   ram_addr,
	output ram_word_t   ram_data,
	input  logic        ram_done,
	output logic        track_wr,
	output track_addr_t track_addr,
	output ram_word_t   track_data,
	output logic        dl_wait
);

	localparam ram_addr_t BIOS_BASE = ram_addr_t'(BIOS_START);
	localparam ram_addr_t EXE_BASE  = ram_addr_t'(EXE_START);

	logic      to_ram;
	logic      to_track;
	ram_addr_t base_addr;

	assign to_ram    = word_valid && ((dl_kind == DL_BIOS) || (dl_kind == DL_EXE));
	assign to_track  = word_valid && (dl_kind == DL_CDINFO);
	assign base_addr = (dl_kind == DL_EXE) ? EXE_BASE : BIOS_BASE;

	// ==================================================
	// Request strobes and host wait
	// ==================================================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			ram_req  <= 1'b0;
			track_wr <= 1'b0;
			dl_wait  <= 1'b0;
		end else begin
			ram_req  <= to_ram;
			track_wr <= to_track;
			// Done or end of download releases the host
			if (ram_done || (dl_kind == DL_NONE)) begin
				dl_wait <= 1'b0;
			end
			if (to_ram) begin
				dl_wait <= 1'b1;
			end
		end
	end

	// Address and data, valid with their strobes
	always_ff @(posedge clk_1x) begin
		if (to_ram) begin
			ram_addr <= word_offset + base_addr;
			ram_data <= word;
		end
		if (to_track) begin
			// Word index within the track table
			track_addr <= word_offset[10:2];
			track_data <= word;
		end
	end

endmodule

// ==== half_word_packer.sv ====
// Collects 16-bit host half-words into one payload of a 32-bit multiple width.
// Used for single RAM words and for the 128-bit cheat codes; the payload type
// sets the number of halves.

`timescale 1ns/1ps

module half_word_packer import sys_pkg::*; #(
	parameter type payload_t = ram_word_t
) (
	input  logic      clk_1x,
	input  logic      rst_n,
	input  logic      half_wr,
	input  ram_addr_t half_offset,
	input  half_t     half_data,
	output payload_t  payload,
	output ram_addr_t payload_offset,
	output logic      payload_valid
);

	localparam int PAYLOAD_W = $bits(payload_t);
	localparam int HALVES    = PAYLOAD_W / HALF_W;
	localparam int FIELDS    = PAYLOAD_W / WORD_W;
	localparam int IDX_W     = $clog2(HALVES);

	// Byte offset bits below the payload alignment
	localparam ram_addr_t ALIGN_MASK = ram_addr_t'(PAYLOAD_W / 8 - 1);

	logic [IDX_W-1:0]     half_idx;
	logic                 last_half;
	int unsigned          half_pos;
	logic [PAYLOAD_W-1:0] payload_q;

	assign half_idx  = half_offset[IDX_W:1];
	assign last_half = (half_idx == IDX_W'(HALVES - 1));

	// Pair f lands in field F-1-f with the even half in the low 16 bits
	always_comb begin
		half_pos = (FIELDS - 1 - int'(half_idx >> 1)) * WORD_W;
		if (half_idx[0]) begin
			half_pos = half_pos + HALF_W;
		end
	end

	// Payload and its offset hold until the next complete payload
	always_ff @(posedge clk_1x) begin
		if (half_wr) begin
			payload_q[half_pos +: HALF_W] <= half_data;
			if (half_idx == '0) begin
				payload_offset <= half_offset & ~ALIGN_MASK;
			end
		end
	end

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			payload_valid <= 1'b0;
		end else begin
			payload_valid <= half_wr & last_half;
		end
	end

	assign payload = payload_t'(payload_q);

endmodule

// ==== download_decoder.sv ====
// Decodes the host download index into a registered download kind.
// Also gives the EXE load pulse after an EXE image ends and the cheat clear
// pulse when a cheat download begins.

`timescale 1ns/1ps

module download_decoder import sys_pkg::*; (
	input  logic       clk_1x,
	input  logic       rst_n,
	input  logic       dl_active,
	input  logic [7:0] dl_index,
	output dl_kind_t   dl_kind,
	output logic       load_exe,
	output logic       code_reset
);

	logic is_exe;
	logic is_code;
	logic exe_d1;
	logic exe_d2;
	logic code_d1;

	assign is_exe  = (dl_kind == DL_EXE);
	assign is_code = (dl_kind == DL_CODE);

	// Kind follows active flag and index one cycle later
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			dl_kind <= DL_NONE;
		end else if (!dl_active) begin
			dl_kind <= DL_NONE;
		end else begin
			case (dl_index)
				INDEX_BIOS:   dl_kind <= DL_BIOS;
				INDEX_EXE:    dl_kind <= DL_EXE;
				INDEX_CDINFO: dl_kind <= DL_CDINFO;
				INDEX_CODE:   dl_kind <= DL_CODE;
				default:      dl_kind <= DL_NONE;
			endcase
		end
	end

	// ==================================================
	// Edge pulses
	// ==================================================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			exe_d1     <= 1'b0;
			exe_d2     <= 1'b0;
			code_d1    <= 1'b0;
			load_exe   <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			exe_d1     <= is_exe;
			exe_d2     <= exe_d1;
			code_d1    <= is_code;
			// Falling EXE flag, seen through the second delay stage
			load_exe   <= exe_d2 & ~exe_d1;
			// Rising CODE flag clears the cheat table
			code_reset <= is_code & ~code_d1;
		end
	end

endmodule

// ==== sys_pkg.sv ====
// Shared widths, download indexes and payload types for the host download path.
// Imported by every module of the download block.

package sys_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int HALF_W  = 16;
	localparam int WORD_W  = 32;
	localparam int ADDR_W  = 27;
	localparam int TRACK_W = 9;
	localparam int CODE_W  = 4 * WORD_W;

	// ==================================================
	// Payload types
	// ==================================================
	typedef logic [HALF_W-1:0]  half_t;
	typedef logic [WORD_W-1:0]  ram_word_t;
	typedef logic [ADDR_W-1:0]  ram_addr_t;
	typedef logic [TRACK_W-1:0] track_addr_t;

	// Flags 127:96, address 95:64, compare 63:32, replace 31:0
	typedef logic [CODE_W-1:0] cheat_code_t;

	// Host download indexes
	localparam logic [7:0] INDEX_BIOS   = 8'd0;
	localparam logic [7:0] INDEX_EXE    = 8'd1;
	localparam logic [7:0] INDEX_CDINFO = 8'd251;
	localparam logic [7:0] INDEX_CODE   = 8'd255;

	typedef enum logic [2:0] {
		DL_NONE   = 3'd0,
		DL_BIOS   = 3'd1,
		DL_EXE    = 3'd2,
		DL_CDINFO = 3'd3,
		DL_CODE   = 3'd4
	} dl_kind_t;

endpackage
